//--- common/cdb_consts.svh
/*
 * common data bus queue constants
 * widths of the result fields, slot count of the circular buffer,
 * number of producer ports and number of broadcast lanes
 */
`ifndef CDB_CONSTS_SVH
`define CDB_CONSTS_SVH

// result fields
`define CDB_XLEN        32  // data width
`define CDB_PR_LEN      6   // physical register tag
`define CDB_ROB_LEN     5   // reorder buffer tag

// branch dependency tracking
`define CDB_BRAT_SIZE   4   // dependency vector width
`define CDB_BRAT_LEN    2   // resolution index width

// queue geometry
`define CDB_SLOTS       32
`define CDB_PTR_LEN     5
`define CDB_INPUTS      4   // alu1, alu2, mult1, mult2
`define CDB_LANES       2

`endif

//--- common/cdb_result_pkg.sv
/*
 * execution result types
 * shared by the execution units that produce results and by the
 * common data bus queue that stores and broadcasts them
 */
`include "cdb_consts.svh"

package cdb_result_pkg;

    typedef logic [`CDB_XLEN-1:0]      data_t;
    typedef logic [`CDB_PR_LEN-1:0]    preg_t;
    typedef logic [`CDB_ROB_LEN-1:0]   rob_tag_t;
    typedef logic [`CDB_BRAT_SIZE-1:0] brat_vec_t;   // branch dependency
    typedef logic [`CDB_BRAT_LEN-1:0]  brat_idx_t;

    // one finished result from an execution unit
    typedef struct packed {
        logic      valid;
        data_t     result;
        preg_t     dest_phy_reg;
        rob_tag_t  rob_num;
        logic      take_branch;      // branch outcome
        logic      is_branch;
        brat_vec_t brat_vec;
    } ex_result_t;

    // correct branch resolution
    typedef struct packed {
        logic      valid;
        brat_idx_t index;            // which dependency bit resolved
    } resolve_t;

endpackage

//--- common/cdb_queue_pkg.sv
/*
 * common data bus queue types
 * slot pointers, per-slot flag vectors, counters and the broadcast
 * lane seen by rename, ROB and reservation stations
 */
`include "cdb_consts.svh"

package cdb_queue_pkg;

    import cdb_result_pkg::*;

    typedef logic [`CDB_PTR_LEN-1:0] slot_ptr_t;
    typedef logic [`CDB_SLOTS-1:0]   slot_vec_t;   // one flag per slot
    typedef logic [`CDB_PTR_LEN:0]   occ_cnt_t;    // 0 .. CDB_SLOTS
    typedef logic [2:0]              in_cnt_t;     // 0 .. CDB_INPUTS

    // one broadcast lane
    typedef struct packed {
        logic      valid;
        data_t     result;
        preg_t     dest_phy_reg;
        rob_tag_t  rob_num;
        logic      take_branch;
        logic      is_branch;
        brat_vec_t brat_vec;
    } cdb_lane_t;

endpackage

//--- cdb_queue/cdb_entry.sv
/*
 * common data bus queue slot
 * holds one finished result until it is broadcast, drops it on a
 * mispredict that covers its dependency vector and rewrites that
 * vector when branches resolve correctly
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb_entry
    import cdb_result_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       write,
    input  ex_result_t write_data,
    input  logic       retire,
    input  logic       mispredict,
    input  brat_vec_t  brat_mis,
    input  resolve_t   resolve [1:0],
    output ex_result_t stored,
    output logic       kill
);

    brat_vec_t vec_shift;   // vector after this cycle's resolutions

    // bits index..1 take the bit below, bit 0 clears, upper bits stay
    function automatic brat_vec_t shift_vec(brat_vec_t v, brat_idx_t k);
        brat_vec_t r;
        r = v;
        for (int j = 1; j < `CDB_BRAT_SIZE; j++) begin
            if (j <= int'(k)) begin
                r[j] = v[j-1];
            end
        end
        r[0] = 1'b0;
        return r;
    endfunction

    ////////////////////////////////
    // squash and resolution
    ////////////////////////////////

    assign kill = stored.valid && mispredict && (stored.brat_vec > brat_mis);

    always_comb begin
        vec_shift = stored.brat_vec;
        if (resolve[0].valid) begin
            vec_shift = shift_vec(vec_shift, resolve[0].index);
        end
        if (resolve[1].valid) begin    // applied on top of resolution 0
            vec_shift = shift_vec(vec_shift, resolve[1].index);
        end
    end

    ////////////////////////////////
    // slot storage
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            stored.valid <= 1'b0;
        end else if (write) begin
            stored <= write_data;          // fresh result, no squash or shift
        end else if (retire || kill) begin
            stored.valid <= 1'b0;
        end else begin
            stored.brat_vec <= vec_shift;
        end
    end

    // the allocator must never land on a slot that the head is broadcasting
    a_no_write_on_retire: assert property (
        @(posedge clock) disable iff (reset) !(write && retire)
    ) else $error("slot written while being retired");

endmodule

//--- cdb_queue/cdb_alloc.sv
/*
 * common data bus queue tail allocator
 * packs the valid producer results into consecutive slots starting
 * at the tail, in port order, and advances the tail past them
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb_alloc
    import cdb_result_pkg::*;
    import cdb_queue_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  ex_result_t ex_in      [`CDB_INPUTS-1:0],
    output slot_vec_t  write,
    output ex_result_t write_data [`CDB_SLOTS-1:0],
    output slot_ptr_t  tail,
    output in_cnt_t    incoming
);

    slot_ptr_t place_ptr;   // next free slot while placing
    slot_ptr_t next_tail;

    ////////////////////////////////
    // placement
    ////////////////////////////////

    always_comb begin
        write     = '0;
        incoming  = '0;
        place_ptr = tail;
        for (int s = 0; s < `CDB_SLOTS; s++) begin
            write_data[s] = '0;
        end
        // in port order alu1, alu2, mult1, mult2
        for (int i = 0; i < `CDB_INPUTS; i++) begin
            if (ex_in[i].valid) begin
                write[place_ptr]      = 1'b1;
                write_data[place_ptr] = ex_in[i];
                place_ptr             = place_ptr + 1'b1;   // wraps at 32
                incoming              = incoming + 1'b1;
            end
        end
        next_tail = place_ptr;
    end

    ////////////////////////////////
    // tail register
    ////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            tail <= '0;
        end else begin
            tail <= next_tail;
        end
    end

endmodule

//--- cdb_queue/cdb_head_ctrl.sv
/*
 * common data bus queue head control
 * broadcasts the head slot and the slot after it on the two lanes,
 * retires what was shown and moves the head to the oldest surviving
 * result, skipping slots emptied by a mispredict
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb_head_ctrl
    import cdb_result_pkg::*;
    import cdb_queue_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  ex_result_t stored  [`CDB_SLOTS-1:0],
    input  slot_vec_t  kill,
    input  slot_ptr_t  tail,
    input  in_cnt_t    incoming,
    output slot_vec_t  retire,
    output cdb_lane_t  cdb_out [`CDB_LANES-1:0]
);

    slot_ptr_t head;
    slot_ptr_t head_p1;
    slot_ptr_t base_ptr;     // head after this cycle's retires
    slot_ptr_t scan_ptr;
    slot_ptr_t next_head;
    occ_cnt_t  occ;          // slots from head up to tail, holes included
    occ_cnt_t  nret;         // lanes shown this cycle
    occ_cnt_t  span;         // slots left to scan from base_ptr
    occ_cnt_t  adv;          // how far the head moves
    logic      found;
    logic      lane0_valid;
    logic      lane1_valid;
    logic [`CDB_PTR_LEN+1:0] demand;

    function automatic cdb_lane_t to_lane(ex_result_t r, logic v);
        cdb_lane_t l;
        l.valid        = v;
        l.result       = r.result;
        l.dest_phy_reg = r.dest_phy_reg;
        l.rob_num      = r.rob_num;
        l.take_branch  = r.take_branch;
        l.is_branch    = r.is_branch;
        l.brat_vec     = r.brat_vec;
        return l;
    endfunction

    ////////////////////////////////
    // broadcast lanes
    ////////////////////////////////

    assign head_p1     = head + 1'b1;
    assign lane0_valid = stored[head].valid;
    assign lane1_valid = lane0_valid && stored[head_p1].valid;

    assign cdb_out[0] = to_lane(stored[head], lane0_valid);
    assign cdb_out[1] = to_lane(stored[head_p1], lane1_valid);

    always_comb begin
        retire          = '0;
        retire[head]    = lane0_valid;
        retire[head_p1] = retire[head_p1] | lane1_valid;
    end

    ////////////////////////////////
    // next head search
    ////////////////////////////////

    always_comb begin
        nret      = occ_cnt_t'(lane0_valid) + occ_cnt_t'(lane1_valid);
        base_ptr  = head + slot_ptr_t'(nret);
        span      = occ - nret;
        found     = 1'b0;
        next_head = tail;       // nothing survives, queue drains to tail
        adv       = occ;
        scan_ptr  = base_ptr;
        for (int i = 0; i < `CDB_SLOTS; i++) begin
            scan_ptr = base_ptr + slot_ptr_t'(i);
            if (!found && occ_cnt_t'(i) < span &&
                    stored[scan_ptr].valid && !kill[scan_ptr]) begin
                found     = 1'b1;
                next_head = scan_ptr;
                adv       = nret + occ_cnt_t'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            occ  <= '0;
        end else begin
            head <= next_head;
            occ  <= occ - adv + occ_cnt_t'(incoming);
        end
    end

    // producers rely on the queue never filling up
    assign demand = {1'b0, occ} + {{(`CDB_PTR_LEN-1){1'b0}}, incoming};

    a_no_overflow: assert property (
        @(posedge clock) disable iff (reset) demand <= `CDB_SLOTS
    ) else $error("cdb queue overflow");

endmodule

//--- source/cdb.sv
/*
 * common data bus queue
 * stores up to four finished results per cycle in a 32-slot circular
 * buffer and broadcasts the two oldest on two lanes, squashing on
 * mispredict and shifting dependency vectors on branch resolution
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb
    import cdb_result_pkg::*;
    import cdb_queue_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  ex_result_t ex_in   [`CDB_INPUTS-1:0],  // alu1, alu2, mult1, mult2
    input  logic       mispredict,
    input  brat_vec_t  brat_mis,
    input  resolve_t   resolve [1:0],
    output cdb_lane_t  cdb_out [`CDB_LANES-1:0]
);

    slot_vec_t  write;
    slot_vec_t  retire;
    slot_vec_t  kill;
    slot_ptr_t  tail;
    in_cnt_t    incoming;
    ex_result_t write_data [`CDB_SLOTS-1:0];
    ex_result_t stored     [`CDB_SLOTS-1:0];

    cdb_alloc u_alloc (
        .clock      (clock),
        .reset      (reset),
        .ex_in      (ex_in),
        .write      (write),
        .write_data (write_data),
        .tail       (tail),
        .incoming   (incoming)
    );

    //////////////////////////////
    // slot array
    //////////////////////////////

    for (genvar g = 0; g < `CDB_SLOTS; g++) begin : g_slot
        cdb_entry u_entry (
            .clock      (clock),
            .reset      (reset),
            .write      (write[g]),
            .write_data (write_data[g]),
            .retire     (retire[g]),
            .mispredict (mispredict),
            .brat_mis   (brat_mis),
            .resolve    (resolve),
            .stored     (stored[g]),
            .kill       (kill[g])
        );
    end

    cdb_head_ctrl u_head_ctrl (
        .clock    (clock),
        .reset    (reset),
        .stored   (stored),
        .kill     (kill),
        .tail     (tail),
        .incoming (incoming),
        .retire   (retire),
        .cdb_out  (cdb_out)
    );

endmodule

//--- testbench/cdb_checker.sv
/*
 * common data bus queue checker
 * keeps a model of the stored results in arrival order, compares
 * both broadcast lanes each cycle and ages the model with the
 * squash and resolution rules
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb_checker
    import cdb_result_pkg::*;
    import cdb_queue_pkg::*;
(
    input  logic             clock,
    input  logic             reset,
    input  ex_result_t       ex_in   [`CDB_INPUTS-1:0],
    input  logic             mispredict,
    input  brat_vec_t        brat_mis,
    input  resolve_t         resolve [1:0],
    input  cdb_lane_t        cdb_out [`CDB_LANES-1:0],
    input  logic [8*10-1:0]  test_name,
    output int               value_errors,
    output int               order_errors,
    output int               pending
);

    ex_result_t model [$];  // oldest first, squashed entries stay as holes
    int n_value   = 0;
    int n_order   = 0;
    int n_pending = 0;

    assign value_errors = n_value;
    assign order_errors = n_order;
    assign pending      = n_pending;

    // correct resolution of index k: bits k..1 move up by one, bit 0 clears
    function automatic brat_vec_t resolve_ref(brat_vec_t v, brat_idx_t k);
        brat_vec_t low_mask;
        low_mask = brat_vec_t'((5'd2 << k) - 5'd1);    // bits k..0
        return (v & ~low_mask) | ((v << 1) & low_mask & ~brat_vec_t'(1));
    endfunction

    // one cycle of squash and resolution for a stored entry
    function automatic ex_result_t age_entry(ex_result_t e, logic mis, brat_vec_t bm,
                                             resolve_t r0, resolve_t r1);
        ex_result_t a;
        a = e;
        if (e.valid && mis && (e.brat_vec > bm)) begin
            a.valid = 1'b0;
        end else begin
            if (r0.valid) a.brat_vec = resolve_ref(a.brat_vec, r0.index);
            if (r1.valid) a.brat_vec = resolve_ref(a.brat_vec, r1.index);
        end
        return a;
    endfunction

    task automatic compare_lane(input int l, input cdb_lane_t e, input cdb_lane_t a);
        if (e.valid ? (a !== e) : (a.valid !== 1'b0)) begin
            n_value++;
            $display("ERR %0s lane%0d expected %h actual %h", test_name, l, e, a);
        end
    endtask

    //////////////////////////////
    // per-edge compare and update
    //////////////////////////////

    always @(posedge clock) begin : check_edge
        cdb_lane_t exp0;
        cdb_lane_t exp1;
        if (reset) begin
            model.delete();
        end else begin
            exp0 = '0;
            exp1 = '0;
            if (model.size() > 0) exp0 = cdb_lane_t'(model[0]);
            if (model.size() > 1 && model[1].valid) exp1 = cdb_lane_t'(model[1]);
            compare_lane(0, exp0, cdb_out[0]);
            compare_lane(1, exp1, cdb_out[1]);
            if (cdb_out[1].valid && !cdb_out[0].valid) begin
                n_order++;
                $display("lane 1 carries a result while lane 0 is empty in test %0s",
                         test_name);
            end
            // shown entries retire even when squashed this cycle
            if (exp0.valid) void'(model.pop_front());
            if (exp1.valid) void'(model.pop_front());
            foreach (model[i]) begin
                model[i] = age_entry(model[i], mispredict, brat_mis, resolve[0], resolve[1]);
            end
            while (model.size() > 0 && !model[0].valid) begin
                void'(model.pop_front());   // head skips holes
            end
            for (int p = 0; p < `CDB_INPUTS; p++) begin
                if (ex_in[p].valid) model.push_back(ex_in[p]);
            end
        end
        n_pending = model.size();
    end

endmodule

//--- testbench/cdb_tb.sv
/*
 * common data bus queue testbench
 * clock, reset, directed and random stimulus on the producer ports,
 * mispredicts and resolutions, with a checker watching the lanes
 */
`timescale 1ns/100ps
`include "cdb_consts.svh"

module cdb_tb
    import cdb_result_pkg::*;
    import cdb_queue_pkg::*;
();

    logic            clock;
    logic            reset;
    ex_result_t      ex_in   [`CDB_INPUTS-1:0];
    logic            mispredict;
    brat_vec_t       brat_mis;
    resolve_t        resolve [1:0];
    cdb_lane_t       cdb_out [`CDB_LANES-1:0];
    logic [8*10-1:0] test_name;
    int              value_errors;
    int              order_errors;
    int              pending;        // results the model still expects
    int              timeout_errors;
    integer          seed;

    cdb DUT (
        .clock      (clock),
        .reset      (reset),
        .ex_in      (ex_in),
        .mispredict (mispredict),
        .brat_mis   (brat_mis),
        .resolve    (resolve),
        .cdb_out    (cdb_out)
    );

    cdb_checker u_checker (
        .clock        (clock),
        .reset        (reset),
        .ex_in        (ex_in),
        .mispredict   (mispredict),
        .brat_mis     (brat_mis),
        .resolve      (resolve),
        .cdb_out      (cdb_out),
        .test_name    (test_name),
        .value_errors (value_errors),
        .order_errors (order_errors),
        .pending      (pending)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    task automatic clear_inputs;
        for (int p = 0; p < `CDB_INPUTS; p++) begin
            ex_in[p] = '0;
        end
        mispredict = 1'b0;
        brat_mis   = '0;
        resolve[0] = '0;
        resolve[1] = '0;
    endtask

    function automatic ex_result_t random_result(brat_vec_t vec);
        ex_result_t r;
        r.valid        = 1'b1;
        r.result       = $random(seed);
        r.dest_phy_reg = preg_t'($random(seed));
        r.rob_num      = rob_tag_t'($random(seed));
        r.take_branch  = 1'($random(seed));
        r.is_branch    = 1'($random(seed));
        r.brat_vec     = vec;
        return r;
    endfunction

    task automatic random_events;
        if (($random(seed) & 7) == 0) begin
            mispredict = 1'b1;
            brat_mis   = brat_vec_t'($random(seed));
        end
        resolve[0].valid = (($random(seed) & 3) == 0);
        resolve[0].index = brat_idx_t'($random(seed));
        resolve[1].valid = (($random(seed) & 3) == 0);
        resolve[1].index = brat_idx_t'($random(seed));
    endtask

    // idle cycles until lane 0 shows a result
    task automatic wait_lane0(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            clear_inputs();
            n++;
        end while (!cdb_out[0].valid && n < limit);
        if (!cdb_out[0].valid) begin
            timeout_errors++;
            $display("timeout: no result on lane 0 within %0d cycles in test %0s",
                     limit, test_name);
        end
    endtask

    // idle cycles until the queue and the model are both empty
    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            clear_inputs();
            n++;
        end while ((cdb_out[0].valid || pending != 0) && n < limit);
        if (cdb_out[0].valid || pending != 0) begin
            timeout_errors++;
            $display("timeout: queue not drained within %0d cycles in test %0s",
                     limit, test_name);
        end
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////

    task automatic run_single;
        test_name = "single    ";
        for (int p = 0; p < `CDB_INPUTS; p++) begin
            @(negedge clock);
            clear_inputs();
            ex_in[p] = random_result(brat_vec_t'($random(seed)));
            wait_lane0(8);
            wait_drain(16);
        end
    endtask

    task automatic run_burst;
        test_name = "burst_four";
        repeat (2) begin
            @(negedge clock);
            for (int p = 0; p < `CDB_INPUTS; p++) begin
                ex_in[p] = random_result(brat_vec_t'($random(seed)));
            end
            wait_drain(16);
        end
    endtask

    task automatic run_mispredict;
        test_name = "mispredict";
        for (int c = 0; c < 3; c++) begin
            @(negedge clock);
            for (int p = 0; p < `CDB_INPUTS; p++) begin
                ex_in[p] = random_result(brat_vec_t'((c * 4 + p) * 7));
            end
        end
        @(negedge clock);
        clear_inputs();
        mispredict = 1'b1;
        brat_mis   = 4'd5;
        ex_in[0]   = random_result(4'hf);    // written this cycle, survives
        wait_drain(24);
    endtask

    task automatic run_resolve;
        test_name = "resolve   ";
        repeat (2) begin
            @(negedge clock);
            for (int p = 0; p < `CDB_INPUTS; p++) begin
                ex_in[p] = random_result(brat_vec_t'($random(seed)));
            end
        end
        @(negedge clock);
        clear_inputs();
        resolve[0].valid = 1'b1;
        resolve[0].index = 2'd2;
        @(negedge clock);
        clear_inputs();
        resolve[0].valid = 1'b1;
        resolve[0].index = 2'd1;
        resolve[1].valid = 1'b1;
        resolve[1].index = 2'd3;
        ex_in[2] = random_result(4'hb);       // not shifted this cycle
        wait_drain(24);
    endtask

    // bursts of 4 active cycles and 8 idle ones keep the buffer below capacity
    task automatic run_random(input int bursts);
        test_name = "random_mix";
        for (int b = 0; b < bursts; b++) begin
            for (int c = 0; c < 12; c++) begin
                @(negedge clock);
                clear_inputs();
                if (c < 4) begin
                    for (int p = 0; p < `CDB_INPUTS; p++) begin
                        if (($random(seed) & 1) != 0) begin
                            ex_in[p] = random_result(brat_vec_t'($random(seed)));
                        end
                    end
                end
                random_events();
            end
        end
        wait_drain(40);
    endtask

    initial begin
        seed           = 32'h9a2b_229c;
        timeout_errors = 0;
        test_name      = "reset_idle";
        reset          = 1'b1;
        clear_inputs();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        repeat (4) @(negedge clock);   // lanes stay empty

        run_single();
        run_burst();
        run_mispredict();
        run_resolve();
        run_random(40);

        $display("errors: value %0d, lane order %0d, timeout %0d",
                 value_errors, order_errors, timeout_errors);
        if (value_errors + order_errors + timeout_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- cdb.f
+incdir+common
common/cdb_result_pkg.sv
common/cdb_queue_pkg.sv
cdb_queue/cdb_entry.sv
cdb_queue/cdb_alloc.sv
cdb_queue/cdb_head_ctrl.sv
source/cdb.sv
testbench/cdb_checker.sv
testbench/cdb_tb.sv

//--- Makefile
# Verilator flow for the common data bus queue

TOP   = cdb_tb
BUILD = build

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f cdb.f --top-module $(TOP)

# the run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing -f cdb.f --top-module $(TOP) -Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf $(BUILD)
